//--- design/cnn_cfg_pkg.sv
package cnn_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Kernel geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Kernel side; window and adder tree size follow from it.
    localparam int K = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Image and scaling defaults.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Raster size of one frame.
    localparam int IMG_W_DEF = 8;
    localparam int IMG_H_DEF = 6;

    // Right shift applied after ReLU.
    localparam int OUT_SHIFT_DEF = 4;

endpackage

//--- design/cnn_data_pkg.sv
package cnn_data_pkg;

    // Word widths.
    localparam int PIX_W  = 8;
    localparam int WGT_W  = 8;
    localparam int BIAS_W = 16;
    localparam int SUM_W  = 20;
    localparam int OUT_W  = 8;

    // Input pixel, unsigned.
    typedef logic [PIX_W-1:0] pixel_t;

    // Kernel weight and bias, two's complement.
    typedef logic signed [WGT_W-1:0]  weight_t;
    typedef logic signed [BIAS_W-1:0] bias_t;

    // Row major, [0][0] is oldest row and leftmost column.
    typedef pixel_t [0:cnn_cfg_pkg::K-1][0:cnn_cfg_pkg::K-1] window_t;

    // Nine products of 17 bits fit here without overflow.
    typedef logic signed [SUM_W-1:0] sum_t;

    typedef logic [OUT_W-1:0] out_t;

endpackage

//--- design/stream_if.sv
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Window stream, decode to execute.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface window_if;
    logic                  valid;
    cnn_data_pkg::window_t win;
    logic                  first;
    logic                  last;

    modport src (
        output valid,
        output win,
        output first,
        output last
    );

    modport dst (
        input valid,
        input win,
        input first,
        input last
    );
endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sum stream, execute to result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface sum_if;
    logic               valid;
    cnn_data_pkg::sum_t sum;
    logic               first;
    logic               last;

    modport src (output valid, output sum, output first, output last);
    modport dst (input valid, input sum, input first, input last);
endinterface

//--- design/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic                 i_in_valid,
    input  cnn_data_pkg::pixel_t i_in_pixel,

    window_if.src                o_win
);

    localparam int K  = cnn_cfg_pkg::K;
    localparam int XW = $clog2(IMG_W);
    localparam int YW = $clog2(IMG_H);

    logic [XW-1:0] x_cnt;
    logic [YW-1:0] y_cnt;
    logic          x_end;
    logic          y_end;
    logic          win_ready;

    // Previous K-1 rows, oldest first.
    cnn_data_pkg::pixel_t row_mem [0:K-2][0:IMG_W-1];
    cnn_data_pkg::pixel_t new_col [0:K-1];

    cnn_data_pkg::window_t win_q;
    logic                  valid_q;
    logic                  first_q;
    logic                  last_q;

    assign x_end     = (x_cnt == XW'(IMG_W - 1));
    assign y_end     = (y_cnt == YW'(IMG_H - 1));
    assign win_ready = (x_cnt >= XW'(K - 1)) && (y_cnt >= YW'(K - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster position.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (i_in_valid) begin
            if (x_end) begin
                x_cnt <= '0;
                // Wrap straight into the next frame.
                y_cnt <= y_end ? '0 : y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Row memories and window.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Column under the current pixel, top to bottom.
    always_comb begin
        for (int r = 0; r < K - 1; r++) begin
            new_col[r] = row_mem[r][x_cnt];
        end
        new_col[K-1] = i_in_pixel;
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            // Each row moves up one slot at this column.
            for (int r = 0; r < K - 2; r++) begin
                row_mem[r][x_cnt] <= row_mem[r+1][x_cnt];
            end
            row_mem[K-2][x_cnt] <= i_in_pixel;

            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
                win_q[r][K-1] <= new_col[r];
            end
        end
    end

    // Strobes line up with the window just shifted in.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= i_in_valid && win_ready;
            first_q <= i_in_valid && (x_cnt == XW'(K - 1)) && (y_cnt == YW'(K - 1));
            last_q  <= i_in_valid && x_end && y_end;
        end
    end

    assign o_win.valid = valid_q;
    assign o_win.win   = win_q;
    assign o_win.first = first_q;
    assign o_win.last  = last_q;

endmodule

//--- design/conv_engine.sv
`timescale 1ns/1ps

module conv_engine (
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  i_w_we,
    input  logic [3:0]            i_w_addr,
    input  cnn_data_pkg::weight_t i_w_data,

    window_if.dst                 i_win,
    sum_if.src                    o_sum
);

    localparam int K = cnn_cfg_pkg::K;
    localparam int N = K * K;

    cnn_data_pkg::weight_t w_reg [0:N-1];

    cnn_data_pkg::sum_t prod_q [0:N-1];
    logic               p_valid;
    logic               p_first;
    logic               p_last;

    cnn_data_pkg::sum_t tree_sum;
    cnn_data_pkg::sum_t sum_q;
    logic               s_valid;
    logic               s_first;
    logic               s_last;

    // Weight index is row * K + column of the window.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int k = 0; k < N; k++) begin
                w_reg[k] <= '0;
            end
        end else if (i_w_we && (i_w_addr < 4'(N))) begin
            w_reg[i_w_addr] <= i_w_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1, products.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (i_win.valid) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K; c++) begin
                    // Pixel is zero extended so it stays positive.
                    prod_q[r*K+c] <= cnn_data_pkg::sum_t'($signed({1'b0, i_win.win[r][c]}))
                                   * cnn_data_pkg::sum_t'(w_reg[r*K+c]);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2, adder tree.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        tree_sum = '0;
        for (int k = 0; k < N; k++) begin
            tree_sum = tree_sum + prod_q[k];
        end
    end

    always_ff @(posedge clk) begin
        if (p_valid) begin
            sum_q <= tree_sum;
        end
    end

    // Strobes ride along both stages.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p_valid <= 1'b0;
            p_first <= 1'b0;
            p_last  <= 1'b0;
            s_valid <= 1'b0;
            s_first <= 1'b0;
            s_last  <= 1'b0;
        end else begin
            p_valid <= i_win.valid;
            p_first <= i_win.valid && i_win.first;
            p_last  <= i_win.valid && i_win.last;
            s_valid <= p_valid;
            s_first <= p_first;
            s_last  <= p_last;
        end
    end

    assign o_sum.valid = s_valid;
    assign o_sum.sum   = sum_q;
    assign o_sum.first = s_first;
    assign o_sum.last  = s_last;

endmodule

//--- design/activation_unit.sv
`timescale 1ns/1ps

module activation_unit #(
    parameter int OUT_SHIFT = 4
) (
    input  logic                clk,
    input  logic                reset_n,

    input  logic                i_bias_we,
    input  cnn_data_pkg::bias_t i_bias,

    sum_if.dst                  i_sum,

    output logic                o_out_valid,
    output cnn_data_pkg::out_t  o_out_pixel,
    output logic                o_frame_done
);

    // One guard bit over the sum for the bias add.
    localparam int ACC_W = cnn_data_pkg::SUM_W + 1;

    cnn_data_pkg::bias_t     bias_q;
    logic signed [ACC_W-1:0] acc;
    logic [ACC_W-1:0]        relu;
    logic [ACC_W-1:0]        shifted;
    cnn_data_pkg::out_t      sat;
    logic                    frame_open;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bias_q <= '0;
        end else if (i_bias_we) begin
            bias_q <= i_bias;
        end
    end

    // Bias, ReLU, scale, clamp.
    always_comb begin
        acc     = i_sum.sum + bias_q;
        relu    = acc[ACC_W-1] ? '0 : acc;
        shifted = relu >> OUT_SHIFT;
        sat     = (shifted > ACC_W'(255)) ? 8'hff : shifted[cnn_data_pkg::OUT_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (i_sum.valid) begin
            o_out_pixel <= sat;
        end
    end

    // Frame done only closes a frame that was opened.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_out_valid  <= 1'b0;
            o_frame_done <= 1'b0;
            frame_open   <= 1'b0;
        end else begin
            o_out_valid  <= i_sum.valid;
            o_frame_done <= i_sum.valid && i_sum.last && (frame_open || i_sum.first);
            if (i_sum.valid && i_sum.last) begin
                frame_open <= 1'b0;
            end else if (i_sum.valid && i_sum.first) begin
                frame_open <= 1'b1;
            end
        end
    end

endmodule

//--- design/cnn_stage_top.sv
`timescale 1ns/1ps

module cnn_stage_top #(
    parameter int IMG_W     = cnn_cfg_pkg::IMG_W_DEF,
    parameter int IMG_H     = cnn_cfg_pkg::IMG_H_DEF,
    parameter int OUT_SHIFT = cnn_cfg_pkg::OUT_SHIFT_DEF
) (
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  i_in_valid,
    input  cnn_data_pkg::pixel_t  i_in_pixel,

    input  logic                  i_w_we,
    input  logic [3:0]            i_w_addr,
    input  cnn_data_pkg::weight_t i_w_data,
    input  logic                  i_bias_we,
    input  cnn_data_pkg::bias_t   i_bias,

    output logic                  o_out_valid,
    output cnn_data_pkg::out_t    o_out_pixel,
    output logic                  o_frame_done
);

    window_if win_bus ();
    sum_if    sum_bus ();

    // Decode.
    line_buffer #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_line_buffer (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_pixel (i_in_pixel),
        .o_win      (win_bus.src)
    );

    // Execute.
    conv_engine u_conv_engine (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_w_we   (i_w_we),
        .i_w_addr (i_w_addr),
        .i_w_data (i_w_data),
        .i_win    (win_bus.dst),
        .o_sum    (sum_bus.src)
    );

    // Result.
    activation_unit #(
        .OUT_SHIFT (OUT_SHIFT)
    ) u_activation_unit (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_bias_we    (i_bias_we),
        .i_bias       (i_bias),
        .i_sum        (sum_bus.dst),
        .o_out_valid  (o_out_valid),
        .o_out_pixel  (o_out_pixel),
        .o_frame_done (o_frame_done)
    );

endmodule

//--- testbench/tb_cnn_stage.sv
`timescale 1ns/1ps

module tb_cnn_stage;

    localparam int IMG_W   = cnn_cfg_pkg::IMG_W_DEF;
    localparam int IMG_H   = cnn_cfg_pkg::IMG_H_DEF;
    localparam int NW      = cnn_cfg_pkg::K * cnn_cfg_pkg::K;
    localparam int N_PIX   = IMG_W * IMG_H;
    localparam int N_OUT   = (IMG_W - 2) * (IMG_H - 2);
    localparam int FRAMES  = 2;
    localparam int LATENCY = 4;
    localparam int MAX_GAP = 3;
    localparam int TIMEOUT = 500;

    logic                  clk;
    logic                  reset_n;
    logic                  i_in_valid;
    cnn_data_pkg::pixel_t  i_in_pixel;
    logic                  i_w_we;
    logic [3:0]            i_w_addr;
    cnn_data_pkg::weight_t i_w_data;
    logic                  i_bias_we;
    cnn_data_pkg::bias_t   i_bias;
    logic                  o_out_valid;
    cnn_data_pkg::out_t    o_out_pixel;
    logic                  o_frame_done;

    int trace_w [0:FRAMES-1][0:NW-1];
    int trace_b [0:FRAMES-1];
    int trace_p [0:FRAMES-1][0:N_PIX-1];
    int trace_e [0:FRAMES-1][0:N_OUT-1];

    // Expected results in output order.
    cnn_data_pkg::out_t exp_pix_q [$];
    logic               exp_done_q [$];
    int                 issue_q [$];
    int                 cycle_cnt;
    integer             seed = 32'h2d78_190b;

    cnn_stage_top #(
        .IMG_W     (IMG_W),
        .IMG_H     (IMG_H),
        .OUT_SHIFT (cnn_cfg_pkg::OUT_SHIFT_DEF)
    ) UUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_pixel   (i_in_pixel),
        .i_w_we       (i_w_we),
        .i_w_addr     (i_w_addr),
        .i_w_data     (i_w_data),
        .i_bias_we    (i_bias_we),
        .i_bias       (i_bias),
        .o_out_valid  (o_out_valid),
        .o_out_pixel  (o_out_pixel),
        .o_frame_done (o_frame_done)
    );

    always #50 clk = ~clk;

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Error handling and compares.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic report_problem(input string why);
        $display("%0t ns: %s", $time, why);
        abort_run();
    endtask

    task automatic check_pixel(input cnn_data_pkg::out_t want, input cnn_data_pkg::out_t got);
        if (got !== want) begin
            $display("[ERROR] %0t ns: o_out_pixel expected %0d, got %0d", $time, want, got);
            abort_run();
        end
    endtask

    task automatic check_done(input logic want, input logic got);
        if (got !== want) begin
            $display("[ERROR] %0t ns: o_frame_done expected %0b, got %0b", $time, want, got);
            abort_run();
        end
    endtask

    task automatic verify_latency(input int issued, input int now);
        if (now - issued != LATENCY) begin
            $display("[ERROR] %0t ns: o_out_valid latency expected %0d, got %0d",
                     $time, LATENCY, now - issued);
            abort_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Trace file.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic read_value(input int fd, output int v);
        int n;
        n = $fscanf(fd, "%d", v);
        if (n != 1) begin
            report_problem("trace file holds a malformed number");
        end
    endtask

    task automatic read_trace();
        int               fd;
        int               n;
        int               f;
        int               v;
        int               np [0:FRAMES-1] = '{default: 0};
        int               ne [0:FRAMES-1] = '{default: 0};
        logic [31:0]      tag;
        logic [8*256-1:0] rest;
        fd = $fopen("testbench/cnn_stage_trace.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open the trace file");
        end
        f = -1;
        n = $fscanf(fd, "%s", tag);
        while (n == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "W" && f < FRAMES - 1) begin
                f++;
                for (int k = 0; k < NW; k++) begin
                    read_value(fd, v);
                    trace_w[f][k] = v;
                end
            end else if (tag == "B" && f >= 0) begin
                read_value(fd, v);
                trace_b[f] = v;
            end else if (tag == "P" && f >= 0 && np[f] + IMG_W <= N_PIX) begin
                for (int x = 0; x < IMG_W; x++) begin
                    read_value(fd, v);
                    trace_p[f][np[f]] = v;
                    np[f]++;
                end
            end else if (tag == "E" && f >= 0 && ne[f] + IMG_W - 2 <= N_OUT) begin
                for (int x = 0; x < IMG_W - 2; x++) begin
                    read_value(fd, v);
                    trace_e[f][ne[f]] = v;
                    ne[f]++;
                end
            end else begin
                report_problem("trace file holds an unknown or misplaced line");
            end
            n = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        for (int g = 0; g < FRAMES; g++) begin
            if (np[g] != N_PIX || ne[g] != N_OUT) begin
                report_problem("a frame in the trace file has the wrong size");
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_coefficients(input int f);
        for (int k = 0; k < NW; k++) begin
            i_w_we   = 1'b1;
            i_w_addr = 4'(k);
            i_w_data = cnn_data_pkg::weight_t'(trace_w[f][k]);
            @(negedge clk);
        end
        i_w_we    = 1'b0;
        i_bias_we = 1'b1;
        i_bias    = cnn_data_pkg::bias_t'(trace_b[f]);
        @(negedge clk);
        i_bias_we = 1'b0;
    endtask

    task automatic drive_frame(input int f, input bit with_gaps);
        int gap;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                i_in_valid = 1'b1;
                i_in_pixel = cnn_data_pkg::pixel_t'(trace_p[f][y*IMG_W+x]);
                // This pixel completes a window.
                if (x >= 2 && y >= 2) begin
                    issue_q.push_back(cycle_cnt);
                end
                @(negedge clk);
                i_in_valid = 1'b0;
                if (with_gaps) begin
                    gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                    repeat (gap) @(negedge clk);
                end
            end
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_pix_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_pix_q.size() != 0) begin
            report_problem("timed out waiting for the outputs of a frame");
        end
    endtask

    // Outputs are sampled away from the active edge.
    always @(negedge clk) begin
        if (reset_n === 1'b1) begin
            if (o_out_valid !== 1'b1) begin
                check_done(1'b0, o_frame_done);
            end else if (exp_pix_q.size() == 0) begin
                report_problem("an output appeared with no expected value left");
            end else begin
                check_pixel(exp_pix_q.pop_front(), o_out_pixel);
                check_done(exp_done_q.pop_front(), o_frame_done);
                verify_latency(issue_q.pop_front(), cycle_cnt);
            end
        end
    end

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        i_in_valid = 1'b0;
        i_in_pixel = '0;
        i_w_we     = 1'b0;
        i_w_addr   = '0;
        i_w_data   = '0;
        i_bias_we  = 1'b0;
        i_bias     = '0;
        read_trace();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int f = 0; f < FRAMES; f++) begin
            load_coefficients(f);
            for (int i = 0; i < N_OUT; i++) begin
                exp_pix_q.push_back(cnn_data_pkg::out_t'(trace_e[f][i]));
                exp_done_q.push_back(i == N_OUT - 1);
            end
            // First frame back to back, later ones with idle gaps.
            drive_frame(f, f > 0);
            wait_drained();
            @(negedge clk);
        end
        // Quiet period so a stray output gets caught.
        repeat (10) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- vlog.f
design/cnn_cfg_pkg.sv
design/cnn_data_pkg.sv
design/stream_if.sv
design/line_buffer.sv
design/conv_engine.sv
design/activation_unit.sv
design/cnn_stage_top.sv
testbench/tb_cnn_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CNN stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log
BIN=sim_cnn_stage

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_cnn_stage -f vlog.f -o "$BIN"

status=0
./obj_dir/"$BIN" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation finished cleanly"

//--- testbench/cnn_stage_trace.txt
# Tags: W nine weights row major, B bias, P one row of 8 input pixels,
# E one row of 6 expected outputs. Each W line starts a new frame.
W 0 0 0 0 32 0 0 0 0
B -640
P 0 1 2 3 4 5 6 7
P 9 10 20 21 30 100 147 200
P 3 148 150 19 0 255 60 8
P 7 25 50 75 100 125 130 140
P 11 200 19 20 21 128 127 44
P 250 240 230 220 210 200 190 180
E 0 0 2 20 160 254
E 255 255 0 0 255 80
E 10 60 110 160 210 220
E 255 0 0 2 216 214
W 4 8 -4 0 12 -8 16 -4 8
B -1793
P 5 15 25 35 45 55 65 75
P 35 45 55 65 75 85 95 105
P 65 75 85 95 105 115 125 135
P 95 105 115 125 135 145 155 165
P 125 135 145 155 165 175 185 195
P 155 165 175 185 195 205 215 225
E 0 5 25 45 65 85
E 45 65 85 105 125 145
E 105 125 145 165 185 205
E 165 185 205 225 245 255
